// File: axiToApbWrite.f
+incdir+tb
verilog/axiApbPkg.sv
verilog/wordRequestQueue.sv
verilog/apbRequester.sv
verilog/axiWriteSlave.sv
verilog/axiToApbWrite.sv
tb/tbAxiToApbWrite.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f axiToApbWrite.f \
  --top-module tbAxiToApbWrite \
  -o simAxiToApbWrite

./obj_dir/simAxiToApbWrite | tee sim.log

if grep -q "Regression passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

// File: tb/tbHelpers.svh
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// ------------------------------------------------------------
// random numbers
// ------------------------------------------------------------
// fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic [31:0] randBits(int n);
  logic [31:0] value;
  logic        feedback;
  value = '0;
  for (int i = 0; i < n; i++) begin
    feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], feedback};
    value     = {value[30:0], feedback};
  end
  return value;
endfunction

function automatic awCmd_t makeCmd(axiId_t id, axiAddr_t addr, axiLen_t len,
                                   axiSize_t size, axiBurst_e burst, axiProt_t prot);
  awCmd_t cmd;
  cmd.id    = id;
  cmd.addr  = addr;
  cmd.len   = len;
  cmd.size  = size;
  cmd.burst = burst;
  cmd.prot  = prot;
  return cmd;
endfunction

// ------------------------------------------------------------
// expected target writes
// ------------------------------------------------------------
function automatic axiAddr_t stepAddr(axiAddr_t addr, axiSize_t size, axiBurst_e burst);
  int stepBytes;
  stepBytes = 1 << size;
  if (burst == BurstFixed)
    return addr;
  if (stepBytes < BusBytes)
    return addr + axiAddr_t'(stepBytes); // narrow beat
  return addr - (addr % BusBytes) + axiAddr_t'(BusBytes);
endfunction

task automatic buildExpected(input awCmd_t cmd);
  axiAddr_t addr;
  int       firstLane;
  wordReq_t word;
  expWords.delete();
  addr = cmd.addr;
  for (int b = 0; b <= int'(cmd.len); b++) begin
    firstLane = int'(addr % BusBytes) / ApbWordBytes;
    for (int lane = firstLane; lane < WordsPerBeat; lane++) begin
      // lowest word keeps the beat address as given
      word.addr = (lane == firstLane) ? addr
                : addr - (addr % BusBytes) + axiAddr_t'(lane * ApbWordBytes);
      word.data       = beatData[b][32*lane +: 32];
      word.byteEnable = beatStrb[b][4*lane +: 4];
      word.prot       = cmd.prot;
      if (word.byteEnable != '0)
        expWords.push_back(word);
    end
    addr = stepAddr(addr, cmd.size, cmd.burst);
  end
endtask

// ------------------------------------------------------------
// checks
// ------------------------------------------------------------
task automatic reportError(string msg);
  $display("%0t ns: %s", $time, msg);
  testErrors++;
endtask

task automatic compareWord(string name, wordReq_t got, wordReq_t exp);
  if (got !== exp) begin
    $display("Fail %0t ns %s got %h expected %h", $time, name, got, exp);
    testErrors++;
  end
endtask

task automatic compareResp(string name, axiResp_e got, axiResp_e exp);
  if (got !== exp) begin
    $display("Fail %0t ns %s got %h expected %h", $time, name, got, exp);
    testErrors++;
  end
endtask

task automatic compareId(string name, axiId_t got, axiId_t exp);
  if (got !== exp) begin
    $display("Fail %0t ns %s got %h expected %h", $time, name, got, exp);
    testErrors++;
  end
endtask

`endif

// File: tb/tbAxiToApbWrite.sv
`timescale 1ns/1ns

module tbAxiToApbWrite;
  import axiApbPkg::*;

  localparam int BusWidth      = 64;
  localparam int BusBytes      = BusWidth / 8;
  localparam int WordsPerBeat  = BusBytes / ApbWordBytes;
  localparam int RandomBursts  = 40;
  localparam int NumBursts     = RandomBursts + 6;
  localparam int TimeoutCycles = 200 * NumBursts;

  logic                  ACLK;
  logic                  ARESETn;
  awCmd_t                awCmd;
  logic                  AWVALID;
  logic                  AWREADY;
  logic [BusWidth-1:0]   WDATA;
  logic [BusBytes-1:0]   WSTRB;
  logic                  WLAST;
  logic                  WVALID;
  logic                  WREADY;
  axiId_t                BID;
  axiResp_e              BRESP;
  logic                  BVALID;
  logic                  BREADY;
  logic                  REQ;
  logic                  ACK;
  axiAddr_t              ADDR;
  apbData_t              DATAW;
  byteEnable_t           BE;
  axiProt_t              PROT;

  logic [31:0]         lfsrState = 32'hddad;
  logic [BusWidth-1:0] beatData [4];
  logic [BusBytes-1:0] beatStrb [4];
  wordReq_t            expWords [$];
  wordReq_t            gotWords [$]; // as seen by the target
  int                  ackDelayCfg = 0;
  int                  testErrors  = 0;
  int                  testNum     = 0;
  int                  passedTests = 0;
  int                  failedTests = 0;

  // response of the last burst, still waiting for BREADY
  logic                pendingB = 1'b0;
  string               pendingName;
  axiResp_e            pendingResp;
  int                  pendingBDelay;

  `include "tbHelpers.svh"

  axiToApbWrite #(
    .AxiDataWidth(BusWidth),
    .QueueDepth(4)
  ) axiToApbWrite_inst (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .awCmd(awCmd), .AWVALID(AWVALID), .AWREADY(AWREADY),
    .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID), .WREADY(WREADY),
    .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .REQ(REQ), .ACK(ACK), .ADDR(ADDR), .DATAW(DATAW), .BE(BE), .PROT(PROT)
  );

  initial begin
    ACLK = 1'b0;
    forever #5 ACLK = ~ACLK;
  end

  // all stimulus and sampling 1 ns after the rising edge
  task automatic waitCycle();
    @(posedge ACLK);
    #1;
  endtask

  // ------------------------------------------------------------
  // target side answering REQ after a per-burst delay
  // ------------------------------------------------------------
  initial begin : targetResponder
    int       waited;
    wordReq_t seen;
    waited = 0;
    ACK    = 1'b0;
    forever begin
      waitCycle();
      if (REQ && !ACK) begin
        if (waited >= ackDelayCfg) begin
          seen.addr       = ADDR;
          seen.data       = DATAW;
          seen.byteEnable = BE;
          seen.prot       = PROT;
          gotWords.push_back(seen);
          ACK    = 1'b1;
          waited = 0;
        end else begin
          waited++;
        end
      end else if (!REQ && ACK) begin
        ACK = 1'b0; // four-phase release
      end
    end
  end

  // ------------------------------------------------------------
  // AXI master
  // ------------------------------------------------------------
  // random data with strobes only on the byte lanes of each beat
  task automatic makeBeats(input awCmd_t cmd, input logic fullStrb);
    axiAddr_t            addr;
    int                  stepBytes;
    logic [BusBytes-1:0] mask;
    addr      = cmd.addr;
    stepBytes = 1 << cmd.size;
    for (int b = 0; b <= int'(cmd.len); b++) begin
      for (int k = 0; k < BusWidth / 32; k++)
        beatData[b][32*k +: 32] = randBits(32);
      mask = BusBytes'(((1 << stepBytes) - 1) << int'(addr % BusBytes));
      if (fullStrb)
        beatStrb[b] = mask;
      else
        beatStrb[b] = BusBytes'(randBits(BusBytes)) & mask;
      addr = stepAddr(addr, cmd.size, cmd.burst);
    end
  endtask

  // B handshake of the previous burst while the next AW waits on AWVALID
  task automatic finishResponse();
    if (pendingB) begin
      repeat (pendingBDelay) begin // response held by a low BREADY
        waitCycle();
        if (!BVALID)
          reportError("BVALID dropped while BREADY was low");
        if (AWREADY)
          reportError("AWREADY rose before the B handshake");
        compareResp("BRESP", BRESP, pendingResp);
      end
      BREADY = 1'b1;
      waitCycle();
      BREADY   = 1'b0;
      pendingB = 1'b0;
      if (testErrors == 0)
        passedTests++;
      else
        failedTests++;
      $display("test %0d %s: %s, %0d target writes", testNum, pendingName,
               (testErrors == 0) ? "ok" : "mismatch", gotWords.size());
    end
  endtask

  task automatic runBurst(input string name, input awCmd_t cmd, input logic badLast,
                          input int ackDelay, input int bDelay);
    axiResp_e expResp;
    logic     seen;
    awCmd   = cmd;
    AWVALID = 1'b1;
    finishResponse();

    testNum++;
    testErrors  = 0;
    ackDelayCfg = ackDelay;
    gotWords.delete();
    buildExpected(cmd);
    expResp = badLast ? RespSlvErr : RespOkay;

    do begin
      seen = AWREADY;
      waitCycle();
    end while (!seen);
    AWVALID = 1'b0;

    for (int b = 0; b <= int'(cmd.len); b++) begin
      WDATA  = beatData[b];
      WSTRB  = beatStrb[b];
      WLAST  = (b == int'(cmd.len)) && !badLast;
      WVALID = 1'b1;
      do begin
        seen = WREADY;
        waitCycle();
      end while (!seen);
    end
    WVALID = 1'b0;
    WLAST  = 1'b0;

    // every target write is done by the time BVALID rises
    while (!BVALID)
      waitCycle();
    compareId("BID", BID, cmd.id);
    compareResp("BRESP", BRESP, expResp);
    if (gotWords.size() != expWords.size())
      reportError($sformatf("target saw %0d writes but %0d were expected",
                            gotWords.size(), expWords.size()));
    for (int i = 0; i < gotWords.size() && i < expWords.size(); i++)
      compareWord($sformatf("target write %0d", i), gotWords[i], expWords[i]);

    pendingName   = name;
    pendingResp   = expResp;
    pendingBDelay = bDelay;
    pendingB      = 1'b1;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin : testSequence
    awCmd_t   cmd;
    axiSize_t size;
    axiAddr_t addr;
    logic     badLast;
    awCmd   = '0;
    AWVALID = 1'b0;
    WDATA   = '0;
    WSTRB   = '0;
    WLAST   = 1'b0;
    WVALID  = 1'b0;
    BREADY  = 1'b0;
    ARESETn = 1'b0;
    repeat (16) @(posedge ACLK);
    #1 ARESETn = 1'b1;
    waitCycle();

    cmd = makeCmd(8'h11, 32'h0000_1000, 8'd0, 3'd3, BurstIncr, 3'd2);
    makeBeats(cmd, 1'b1);
    runBurst("full beat", cmd, 1'b0, 1, 0);
    cmd = makeCmd(8'h22, 32'h0000_2000, 8'd3, 3'd3, BurstIncr, 3'd0);
    makeBeats(cmd, 1'b1);
    runBurst("incr full", cmd, 1'b0, 0, 1);
    cmd = makeCmd(8'h23, 32'h0000_2004, 8'd3, 3'd2, BurstIncr, 3'd1);
    makeBeats(cmd, 1'b1);
    runBurst("incr narrow", cmd, 1'b0, 2, 0);
    cmd = makeCmd(8'h33, 32'h0000_3008, 8'd2, 3'd3, BurstFixed, 3'd4);
    makeBeats(cmd, 1'b1);
    runBurst("fixed", cmd, 1'b0, 3, 2);
    cmd = makeCmd(8'h44, 32'h0000_4000, 8'd1, 3'd3, BurstIncr, 3'd0);
    makeBeats(cmd, 1'b1);
    beatStrb[0] = 8'hf0; // lower word void
    beatStrb[1] = 8'h00; // whole beat void
    runBurst("void words", cmd, 1'b0, 0, 0);
    cmd = makeCmd(8'h55, 32'h0000_5000, 8'd2, 3'd2, BurstIncr, 3'd7);
    makeBeats(cmd, 1'b1);
    runBurst("bad wlast", cmd, 1'b1, 1, 3);

    for (int n = 0; n < RandomBursts; n++) begin
      size    = axiSize_t'(randBits(2));
      addr    = axiAddr_t'(randBits(32)) & ~((axiAddr_t'(1) << size) - 1);
      cmd     = makeCmd(axiId_t'(randBits(8)), addr, axiLen_t'(randBits(2)), size,
                        (randBits(1) == 32'd1) ? BurstIncr : BurstFixed,
                        axiProt_t'(randBits(3)));
      makeBeats(cmd, 1'b0);
      badLast = (randBits(3) == 32'd0);
      runBurst($sformatf("random %0d", n), cmd, badLast, int'(randBits(2)), int'(randBits(2)));
    end
    finishResponse(); // last burst has no AW behind it

    $display("tests passed %0d, tests failed %0d", passedTests, failedTests);
    if (failedTests == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial begin : watchdog
    int cycleCount;
    cycleCount = 0;
    while (cycleCount < TimeoutCycles) begin
      @(posedge ACLK);
      cycleCount++;
    end
    $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: verilog/apbRequester.sv
`timescale 1ns/1ns

module apbRequester (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  input  axiApbPkg::wordReq_t    popReq,
  input  logic                   empty,
  input  logic                   ACK,
  output logic                   pop,
  output logic                   busy,
  output logic                   REQ,
  output axiApbPkg::axiAddr_t    ADDR,
  output axiApbPkg::apbData_t    DATAW,
  output axiApbPkg::byteEnable_t BE,
  output axiApbPkg::axiProt_t    PROT
);
  import axiApbPkg::*;

  typedef enum logic [1:0] {Idle, Request, Release} requesterState_e;

  requesterState_e state;
  logic            ackMeta;
  logic            ackSync;

  // ----------------------------------------------------------
  // ACK crosses from the target clock domain
  // ----------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      ackMeta <= 1'b0;
      ackSync <= 1'b0;
    end else begin
      ackMeta <= ACK;
      ackSync <= ackMeta;
    end
  end

  // ----------------------------------------------------------
  // four-phase exchange
  // ----------------------------------------------------------
  assign pop  = (state == Idle) && !empty;
  // low again once the synchronized ACK has dropped
  assign busy = (state == Request) || ((state == Release) && ackSync);

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state <= Idle;
      REQ   <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (!empty) begin
            REQ   <= 1'b1;
            state <= Request;
          end
        end
        Request: begin
          if (ackSync) begin
            REQ   <= 1'b0;
            state <= Release;
          end
        end
        Release: begin
          if (!ackSync)
            state <= Idle; // target has dropped ACK
        end
        default: state <= Idle;
      endcase
    end
  end

  // target lines stay stable while REQ is high
  always_ff @(posedge ACLK) begin
    if (pop) begin
      ADDR  <= popReq.addr;
      DATAW <= popReq.data;
      BE    <= popReq.byteEnable;
      PROT  <= popReq.prot;
    end
  end

endmodule

// File: verilog/axiApbPkg.sv
package axiApbPkg;

  // ----------------------------------------------------------
  // widths
  // ----------------------------------------------------------
  localparam int ApbWordBytes = 4; // bytes per target word

  typedef logic [31:0] axiAddr_t;    // byte address, both sides
  typedef logic [31:0] apbData_t;    // one target word
  typedef logic [3:0]  byteEnable_t; // enables of one target word
  typedef logic [7:0]  axiId_t;      // channel id and id together
  typedef logic [7:0]  axiLen_t;     // beats minus one
  typedef logic [2:0]  axiSize_t;    // log2 bytes per beat
  typedef logic [2:0]  axiProt_t;

  // ----------------------------------------------------------
  // encodings
  // ----------------------------------------------------------
  // wrap and reserved codes fall back to incrementing
  typedef enum logic [1:0] {
    BurstFixed = 2'b00,
    BurstIncr  = 2'b01
  } axiBurst_e;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axiResp_e;

  // ----------------------------------------------------------
  // grouped signals
  // ----------------------------------------------------------
  typedef struct packed {
    axiId_t    id;
    axiAddr_t  addr;
    axiLen_t   len;
    axiSize_t  size;
    axiBurst_e burst;
    axiProt_t  prot;
  } awCmd_t; // 56 bits

  // one target write, queue entry
  typedef struct packed {
    axiAddr_t    addr;
    apbData_t    data;
    byteEnable_t byteEnable;
    axiProt_t    prot;
  } wordReq_t; // 71 bits

endpackage

// File: verilog/axiToApbWrite.sv
`timescale 1ns/1ns

module axiToApbWrite #(
  parameter int AxiDataWidth = 64,
  parameter int QueueDepth   = 4
) (
  input  logic                      ACLK,
  input  logic                      ARESETn,
  // AXI write channels
  input  axiApbPkg::awCmd_t         awCmd,
  input  logic                      AWVALID,
  output logic                      AWREADY,
  input  logic [AxiDataWidth-1:0]   WDATA,
  input  logic [AxiDataWidth/8-1:0] WSTRB,
  input  logic                      WLAST,
  input  logic                      WVALID,
  output logic                      WREADY,
  output axiApbPkg::axiId_t         BID,
  output axiApbPkg::axiResp_e       BRESP,
  output logic                      BVALID,
  input  logic                      BREADY,
  // target side
  output logic                      REQ,
  input  logic                      ACK,
  output axiApbPkg::axiAddr_t       ADDR,
  output axiApbPkg::apbData_t       DATAW,
  output axiApbPkg::byteEnable_t    BE,
  output axiApbPkg::axiProt_t       PROT
);
  import axiApbPkg::*;

  wordReq_t pushReq;
  wordReq_t popReq;
  logic     push;
  logic     pop;
  logic     full;
  logic     empty;
  logic     busy;

  // ----------------------------------------------------------
  // slave -> queue -> requester
  // ----------------------------------------------------------
  axiWriteSlave #(
    .AxiDataWidth(AxiDataWidth)
  ) axiWriteSlave_inst (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .awCmd(awCmd), .AWVALID(AWVALID), .AWREADY(AWREADY),
    .WDATA(WDATA), .WSTRB(WSTRB), .WLAST(WLAST), .WVALID(WVALID), .WREADY(WREADY),
    .BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
    .pushReq(pushReq), .push(push), .full(full), .empty(empty), .busy(busy)
  );

  wordRequestQueue #(
    .QueueDepth(QueueDepth)
  ) wordRequestQueue_inst (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .pushReq(pushReq), .push(push), .pop(pop),
    .popReq(popReq), .full(full), .empty(empty)
  );

  apbRequester apbRequester_inst (
    .ACLK(ACLK), .ARESETn(ARESETn),
    .popReq(popReq), .empty(empty), .ACK(ACK),
    .pop(pop), .busy(busy),
    .REQ(REQ), .ADDR(ADDR), .DATAW(DATAW), .BE(BE), .PROT(PROT)
  );

endmodule

// File: verilog/axiWriteSlave.sv
`timescale 1ns/1ns

module axiWriteSlave #(
  parameter int AxiDataWidth = 64
) (
  input  logic                      ACLK,
  input  logic                      ARESETn,
  input  axiApbPkg::awCmd_t         awCmd,
  input  logic                      AWVALID,
  output logic                      AWREADY,
  input  logic [AxiDataWidth-1:0]   WDATA,
  input  logic [AxiDataWidth/8-1:0] WSTRB,
  input  logic                      WLAST,
  input  logic                      WVALID,
  output logic                      WREADY,
  output axiApbPkg::axiId_t         BID,
  output axiApbPkg::axiResp_e       BRESP,
  output logic                      BVALID,
  input  logic                      BREADY,
  output axiApbPkg::wordReq_t       pushReq,
  output logic                      push,
  input  logic                      full,
  input  logic                      empty,
  input  logic                      busy
);
  import axiApbPkg::*;

  localparam int BusBytes     = AxiDataWidth / 8;
  localparam int WordsPerBeat = BusBytes / ApbWordBytes;
  localparam int IdxWidth     = (WordsPerBeat > 1) ? $clog2(WordsPerBeat) : 1;

  typedef logic [IdxWidth-1:0] wordIdx_t;
  typedef enum logic [2:0] {Idle, Accept, WaitBeat, Slice, Response} writeState_e;

  writeState_e             state;
  awCmd_t                  cmdReg;
  axiAddr_t                beatAddr;   // address of the current beat
  axiLen_t                 beatCnt;
  logic [AxiDataWidth-1:0] wdataReg;
  logic [BusBytes-1:0]     wstrbReg;
  wordIdx_t                wordIdx;    // word lane within the bus
  logic                    firstWord;

  axiAddr_t    busBase;
  axiAddr_t    wordAddr;
  apbData_t    wordData;
  byteEnable_t wordBe;
  logic        wordDone;
  logic        lastWord;
  logic        lastBeat;

  // ----------------------------------------------------------
  // address helpers
  // ----------------------------------------------------------
  function automatic wordIdx_t firstWordIdx(axiAddr_t addr);
    return wordIdx_t'(addr[31:2] % WordsPerBeat);
  endfunction

  function automatic axiAddr_t nextBeatAddr(axiAddr_t addr, axiSize_t size,
                                            axiBurst_e burst);
    axiAddr_t stepBytes;
    stepBytes = axiAddr_t'(1) << size;
    if (burst == BurstFixed)
      return addr;
    if (stepBytes < axiAddr_t'(BusBytes))
      return addr + stepBytes; // narrow beat
    return (addr & ~axiAddr_t'(BusBytes - 1)) + axiAddr_t'(BusBytes);
  endfunction

  // ----------------------------------------------------------
  // word slicing
  // ----------------------------------------------------------
  assign busBase  = beatAddr & ~axiAddr_t'(BusBytes - 1);
  // first word keeps the unaligned beat address
  assign wordAddr = firstWord ? beatAddr
                              : busBase + axiAddr_t'(wordIdx) * axiAddr_t'(ApbWordBytes);
  assign wordData = wdataReg[8*ApbWordBytes*wordIdx +: 8*ApbWordBytes];
  assign wordBe   = wstrbReg[ApbWordBytes*wordIdx +: ApbWordBytes];
  assign lastWord = (wordIdx == wordIdx_t'(WordsPerBeat - 1));
  assign lastBeat = (beatCnt == cmdReg.len);

  // void words are stepped over without a push
  assign wordDone = (state == Slice) && ((wordBe == '0) || !full);
  assign push     = (state == Slice) && (wordBe != '0) && !full;
  assign pushReq  = '{addr: wordAddr, data: wordData, byteEnable: wordBe, prot: cmdReg.prot};

  // ----------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state     <= Idle;
      AWREADY   <= 1'b0;
      WREADY    <= 1'b0;
      BVALID    <= 1'b0;
      BRESP     <= RespOkay;
      BID       <= '0;
      beatCnt   <= '0;
      wordIdx   <= '0;
      firstWord <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (AWVALID) begin
            AWREADY <= 1'b1;
            state   <= Accept;
          end
        end
        Accept: begin // AW handshake on this edge
          AWREADY <= 1'b0;
          WREADY  <= 1'b1;
          BID     <= awCmd.id;
          BRESP   <= RespOkay;
          beatCnt <= '0;
          state   <= WaitBeat;
        end
        WaitBeat: begin
          if (WVALID) begin
            WREADY    <= 1'b0;
            wordIdx   <= firstWordIdx(beatAddr);
            firstWord <= 1'b1;
            if (WLAST != lastBeat)
              BRESP <= RespSlvErr; // length mismatch
            state <= Slice;
          end
        end
        Slice: begin
          if (wordDone) begin
            firstWord <= 1'b0;
            wordIdx   <= wordIdx + 1'b1;
            if (lastWord) begin
              beatCnt <= beatCnt + 1'b1;
              if (lastBeat) begin
                state <= Response;
              end else begin
                WREADY <= 1'b1;
                state  <= WaitBeat;
              end
            end
          end
        end
        Response: begin
          // wait until the last target write has completed
          if (BVALID && BREADY) begin
            BVALID <= 1'b0;
            state  <= Idle;
          end else if (empty && !busy) begin
            BVALID <= 1'b1;
          end
        end
        default: state <= Idle;
      endcase
    end
  end

  // payload, command and beat data
  always_ff @(posedge ACLK) begin
    if (state == Accept) begin
      cmdReg   <= awCmd;
      beatAddr <= awCmd.addr;
    end
    if ((state == WaitBeat) && WVALID) begin
      wdataReg <= WDATA;
      wstrbReg <= WSTRB;
    end
    if (wordDone && lastWord)
      beatAddr <= nextBeatAddr(beatAddr, cmdReg.size, cmdReg.burst);
  end

endmodule

// File: verilog/wordRequestQueue.sv
`timescale 1ns/1ns

module wordRequestQueue #(
  parameter int QueueDepth = 4
) (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  axiApbPkg::wordReq_t pushReq,
  input  logic                push,
  input  logic                pop,
  output axiApbPkg::wordReq_t popReq,
  output logic                full,
  output logic                empty
);
  import axiApbPkg::*;

  localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;

  typedef logic [PtrWidth-1:0] queuePtr_t;
  typedef logic [PtrWidth:0]   queueCount_t;

  wordReq_t    mem [QueueDepth];
  queuePtr_t   wrPtr;
  queuePtr_t   rdPtr;
  queueCount_t count;
  queueCount_t nextCount;
  logic        doPush;
  logic        doPop;

  function automatic queuePtr_t nextPtr(queuePtr_t ptr);
    return (ptr == queuePtr_t'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign doPush    = push && !full;
  assign doPop     = pop && !empty;
  assign nextCount = count + queueCount_t'(doPush) - queueCount_t'(doPop);
  assign popReq    = mem[rdPtr]; // head entry

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      full  <= 1'b0;
      empty <= 1'b1;
    end else begin
      if (doPush)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      count <= nextCount;
      full  <= (nextCount == queueCount_t'(QueueDepth));
      empty <= (nextCount == '0);
    end
  end

  always_ff @(posedge ACLK) begin
    if (doPush)
      mem[wrPtr] <= pushReq;
  end

endmodule
